// File: bench/tb_night_sky.sv
`include "sky_macros.svh"

module tb_night_sky;
	import sky_pkg::*;

	localparam logic [31:0] SEED = 32'h6f2a_5602;
	localparam int DAY_N     = 40;
	localparam int TWINKLE_N = 32;
	localparam int MOON_N    = 210;
	localparam int EDGE_N    = 216;
	localparam int RAND_N    = 2000;
	// reset, first pixel, day, return to night, the loops and the closing frame
	localparam int TEST_CYCLES = 3 + 1 + DAY_N + 1 + TWINKLE_N + MOON_N + EDGE_N + RAND_N + 1;
	localparam int MAX_CYCLES  = TEST_CYCLES + 50;

	logic                  frame_Clk;
	logic                  Reset;
	logic [`COORD_W-1:0]   write_x;
	logic [`COORD_W-1:0]   write_y;
	logic                  isnight;
	sky_layer_t            moon_on_wr;
	logic [`SPRITE_AW-1:0] address;

	logic [31:0] lfsr;
	int          mismatch_errors;
	int          model_errors;
	int          cycles;

	// reference animation state
	int m_count;
	int m_phase;
	int m_star;
	int night_edges;

	int px;
	int py;
	int mx;
	int mw;
	int sh;
	int exp_layer;
	int exp_addr;

	night_sky DUT (
		.frame_Clk  (frame_Clk),
		.Reset      (Reset),
		.write_x    (write_x),
		.write_y    (write_y),
		.isnight    (isnight),
		.moon_on_wr (moon_on_wr),
		.address    (address)
	);

	always #10 frame_Clk = ~frame_Clk;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'hA300_0000;
		else
			return s >> 1;
	endfunction

	function automatic int moon_base(input int p);
		case (p)
			1:       return `MOON_BASE1;
			2:       return `MOON_BASE2;
			3:       return `MOON_BASE3;
			4:       return `MOON_BASE4;
			5:       return `MOON_BASE5;
			6:       return `MOON_BASE6;
			default: return `MOON_BASE0;
		endcase
	endfunction

	function automatic int star_base(input int f);
		case (f)
			1:       return `STAR_BASE1;
			2:       return `STAR_BASE2;
			default: return `STAR_BASE0;
		endcase
	endfunction

	function automatic int star_height(input int f);
		case (f)
			1:       return `STAR_H1;
			2:       return `STAR_H2;
			default: return `STAR_H0;
		endcase
	endfunction

	// right halves sit further right, only the full disc is wide
	function automatic int moon_left(input int p);
		return (p >= 4) ? `MOON_RIGHT_X : `MOON_X;
	endfunction

	function automatic int moon_width(input int p);
		return (p == 0) ? `MOON_FULL_W : `MOON_HALF_W;
	endfunction

	function automatic logic in_box(input int x, input int y, input int x0, input int y0,
		input int w, input int h);
		return x >= x0 && x < x0 + w && y >= y0 && y < y0 + h;
	endfunction

	// count starts at 1, so one twinkle period is one night edge shorter
	function automatic int night_star(input int n);
		int k;
		k = n % (`TWINKLE_PERIOD - 1);
		if (k < `TWINKLE_STEP1 - 1)
			return 0;
		else if (k < `TWINKLE_STEP2 - 1)
			return 1;
		else
			return 2;
	endfunction

	function automatic int night_phase(input int n);
		return (n / (`TWINKLE_PERIOD - 1)) % 7;
	endfunction

	// step the model on every night edge
	always @(posedge frame_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			m_count     <= 1;
			m_star      <= 0;
			m_phase     <= 0;
			night_edges <= 0;
		end
		else if (isnight)
		begin
			night_edges <= night_edges + 1;
			if (m_count + 1 == `TWINKLE_PERIOD)
			begin
				m_count <= 1;
				m_star  <= 0;
				m_phase <= (m_phase + 1) % 7;
			end
			else
			begin
				m_count <= m_count + 1;
				if (m_count + 1 == `TWINKLE_STEP1)
					m_star <= 1;
				else if (m_count + 1 == `TWINKLE_STEP2)
					m_star <= 2;
			end
		end
	end

	// expected layer and address for the pixel on the inputs
	always_comb
	begin
		px        = int'(write_x);
		py        = int'(write_y);
		mx        = moon_left(m_phase);
		mw        = moon_width(m_phase);
		sh        = star_height(m_star);
		exp_layer = LAYER_NONE;
		exp_addr  = 0;
		if (isnight && in_box(px, py, mx, `MOON_Y, mw, `MOON_H))
		begin
			exp_layer = LAYER_MOON;
			exp_addr  = moon_base(m_phase) + (py - `MOON_Y) * mw + px - mx;
		end
		else if (isnight && in_box(px, py, `STAR1_X, `STAR1_Y, `STAR_W, sh))
		begin
			exp_layer = LAYER_STAR1;
			exp_addr  = star_base(m_star) + (py - `STAR1_Y) * `STAR_W + px - `STAR1_X;
		end
		else if (isnight && in_box(px, py, `STAR2_X, `STAR2_Y, `STAR_W, sh))
		begin
			exp_layer = LAYER_STAR2;
			exp_addr  = star_base(m_star) + (py - `STAR2_Y) * `STAR_W + px - `STAR2_X;
		end
	end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		value_ok: assert (expected === actual)
		else
		begin
			mismatch_errors++;
			$display("MISMATCH time=%0t signal=%s expected=%0d actual=%0d",
				$time, name, expected, actual);
		end
	endtask

	task automatic next_frame();
		@(posedge frame_Clk);
		#2;
	endtask

	task automatic set_pixel(input int x, input int y, input logic night);
		write_x = `COORD_W'(x);
		write_y = `COORD_W'(y);
		isnight = night;
	endtask

	task automatic expect_pixel(input int layer, input int addr);
		@(negedge frame_Clk);
		check_value("moon_on_wr", layer, moon_on_wr);
		check_value("address", addr, address);
	endtask

	// one LFSR step per bit
	task automatic rand_bits(input int n, output int v);
		v = 0;
		for (int b = 0; b < n; b++)
		begin
			lfsr = lfsr_step(lfsr);
			v    = (v << 1) | int'(lfsr[0]);
		end
	endtask

	// outputs are compared mid-frame, after the inputs settled
	always @(negedge frame_Clk)
	begin
		if (!Reset)
		begin
			check_value("moon_on_wr", exp_layer, moon_on_wr);
			check_value("address", exp_addr, address);
			model_follows: assert (m_star == night_star(night_edges)
				&& m_phase == night_phase(night_edges))
			else
			begin
				model_errors++;
				$display("model animation state at %0t does not follow the night frame count",
					$time);
			end
		end
	end

	reset_quiet: assert property (@(negedge frame_Clk)
		Reset |-> (moon_on_wr == LAYER_NONE && address == '0))
		else
		begin
			mismatch_errors++;
			$display("MISMATCH time=%0t signal=moon_on_wr/address expected=0/0 actual=%0d/%0d",
				$time, moon_on_wr, address);
		end

	always @(posedge frame_Clk)
	begin
		cycles++;
		if (cycles >= MAX_CYCLES)
		begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("errors: %0d mismatch, %0d model", mismatch_errors, model_errors);
			$display("sim failed");
			$finish;
		end
	end

	initial
	begin
		int x;
		int y;
		int n;
		int p;
		int s;
		int dy;
		int saved_edges;
		frame_Clk       = 1'b0;
		Reset           = 1'b1;
		write_x         = `COORD_W'(`MOON_X);
		write_y         = `COORD_W'(`MOON_Y);
		isnight         = 1'b0;
		lfsr            = SEED;
		mismatch_errors = 0;
		model_errors    = 0;
		cycles          = 0;
		saved_edges     = 0;
		repeat (3) @(posedge frame_Clk);
		#2;
		Reset = 1'b0;

		// first night pixel at the moon corner
		next_frame();
		set_pixel(`MOON_X, `MOON_Y, 1'b1);
		expect_pixel(LAYER_MOON, `MOON_BASE0);

		// daytime, sprite pixels mixed with random ones
		for (int i = 0; i < DAY_N; i++)
		begin
			next_frame();
			if (i == 0)
				saved_edges = night_edges;
			case (i % 4)
				0: set_pixel(`MOON_X + 5, `MOON_Y + 5, 1'b0);
				1: set_pixel(`STAR1_X + 1, `STAR1_Y + 1, 1'b0);
				2: set_pixel(`STAR2_X + 1, `STAR2_Y + 1, 1'b0);
				default:
				begin
					rand_bits(8, x);
					rand_bits(8, y);
					set_pixel(x, y, 1'b0);
				end
			endcase
			expect_pixel(LAYER_NONE, 0);
		end

		// back to night, the star image is where the day left it
		next_frame();
		set_pixel(`STAR1_X + 1, `STAR1_Y + 1, 1'b1);
		expect_pixel(LAYER_STAR1, star_base(night_star(saved_edges)) + `STAR_W + 1);

		// twinkle on one star pixel
		for (int i = 0; i < TWINKLE_N; i++)
		begin
			next_frame();
			set_pixel(`STAR1_X + 1, `STAR1_Y + 1, 1'b1);
			expect_pixel(LAYER_STAR1, star_base(night_star(night_edges)) + `STAR_W + 1);
		end

		// probe column x = 50 through all seven phases
		for (int i = 0; i < MOON_N; i++)
		begin
			next_frame();
			dy = i % `MOON_H;
			set_pixel(50, `MOON_Y + dy, 1'b1);
			p = night_phase(night_edges);
			if (p == 0)
				expect_pixel(LAYER_MOON, `MOON_BASE0 + dy * `MOON_FULL_W + 50);
			else if (p <= 3)
				expect_pixel(LAYER_NONE, 0);
			else
				expect_pixel(LAYER_MOON, moon_base(p) + dy * `MOON_HALF_W + 50 - `MOON_RIGHT_X);
		end

		// right and bottom edges miss, one pixel inside hits
		for (int i = 0; i < EDGE_N; i++)
		begin
			next_frame();
			p = night_phase(night_edges);
			s = night_star(night_edges);
			x = moon_left(p) + moon_width(p);
			y = `STAR2_Y + star_height(s);
			case (i % 9)
				0: set_pixel(x, `MOON_Y, 1'b1);
				1: set_pixel(moon_left(p), `MOON_Y + `MOON_H, 1'b1);
				2: set_pixel(`STAR1_X + `STAR_W, `STAR1_Y, 1'b1);
				3: set_pixel(`STAR1_X, `STAR1_Y + star_height(s), 1'b1);
				4: set_pixel(`STAR2_X + `STAR_W, `STAR2_Y, 1'b1);
				5: set_pixel(`STAR2_X, y, 1'b1);
				6: set_pixel(x - 1, `MOON_Y + `MOON_H - 1, 1'b1);
				7: set_pixel(`STAR1_X + `STAR_W - 1, `STAR1_Y + star_height(s) - 1, 1'b1);
				default: set_pixel(`STAR2_X + `STAR_W - 1, y - 1, 1'b1);
			endcase
			if (i % 9 == 6)
				expect_pixel(LAYER_MOON,
					moon_base(p) + (`MOON_H - 1) * moon_width(p) + moon_width(p) - 1);
			else if (i % 9 == 7)
				expect_pixel(LAYER_STAR1,
					star_base(s) + (star_height(s) - 1) * `STAR_W + `STAR_W - 1);
			else if (i % 9 == 8)
				expect_pixel(LAYER_STAR2,
					star_base(s) + (star_height(s) - 1) * `STAR_W + `STAR_W - 1);
			else
				expect_pixel(LAYER_NONE, 0);
		end

		// random sweep, mostly at night
		for (int i = 0; i < RAND_N; i++)
		begin
			next_frame();
			rand_bits(8, x);
			rand_bits(8, y);
			rand_bits(2, n);
			set_pixel(x, y, n != 0);
		end
		next_frame();
		@(negedge frame_Clk);
		#1;

		$display("errors: %0d mismatch, %0d model", mismatch_errors, model_errors);
		if (mismatch_errors == 0 && model_errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// File: src.f
+incdir+verilog
verilog/sky_pkg.sv
verilog/sky_animator.sv
verilog/sky_hit_detect.sv
verilog/draw_moon.sv
verilog/night_sky.sv
bench/tb_night_sky.sv

// File: verilog/draw_moon.sv
`include "sky_macros.svh"

module draw_moon (
	input  sky_pkg::sky_layer_t   layer,
	input  sky_pkg::moon_phase_t  phase,
	input  sky_pkg::star_frame_t  star_frame,
	input  logic [`COORD_W-1:0]   dist_x,
	input  logic [`COORD_W-1:0]   dist_y,
	output logic [`SPRITE_AW-1:0] address
);
	import sky_pkg::*;

	logic [`SPRITE_AW-1:0] moon_base;
	logic [`SPRITE_AW-1:0] star_base;
	logic [`SPRITE_AW-1:0] base;
	logic [`SPRITE_AW-1:0] row_w;
	logic [`SPRITE_AW-1:0] offset;

	// moon image table
	always_comb
	begin
		case (phase)
			3'd1:    moon_base = `SPRITE_AW'(`MOON_BASE1);
			3'd2:    moon_base = `SPRITE_AW'(`MOON_BASE2);
			3'd3:    moon_base = `SPRITE_AW'(`MOON_BASE3);
			3'd4:    moon_base = `SPRITE_AW'(`MOON_BASE4);
			3'd5:    moon_base = `SPRITE_AW'(`MOON_BASE5);
			3'd6:    moon_base = `SPRITE_AW'(`MOON_BASE6);
			default: moon_base = `SPRITE_AW'(`MOON_BASE0);
		endcase
	end

	// both stars share one set of twinkle images
	always_comb
	begin
		case (star_frame)
			2'd1:    star_base = `SPRITE_AW'(`STAR_BASE1);
			2'd2:    star_base = `SPRITE_AW'(`STAR_BASE2);
			default: star_base = `SPRITE_AW'(`STAR_BASE0);
		endcase
	end

	always_comb
	begin
		case (layer)
			LAYER_MOON:
			begin
				base  = moon_base;
				row_w = (phase == 3'd0) ? `SPRITE_AW'(`MOON_FULL_W)
					: `SPRITE_AW'(`MOON_HALF_W);
			end
			LAYER_STAR1, LAYER_STAR2:
			begin
				base  = star_base;
				row_w = `SPRITE_AW'(`STAR_W);
			end
			default:
			begin
				base  = '0;
				row_w = '0;
			end
		endcase
	end

	// images are stored row by row
	assign offset  = `SPRITE_AW'(dist_y) * row_w + `SPRITE_AW'(dist_x);
	assign address = (layer == LAYER_NONE) ? '0 : base + offset;

	// bounds come from the hit detector, checked here against the row width
	always_comb
	begin
		dist_x_in_row: assert #0 (layer == LAYER_NONE || `SPRITE_AW'(dist_x) < row_w)
			else $error("dist_x %0d outside row of %0d", dist_x, row_w);
	end

endmodule

// File: verilog/night_sky.sv
`include "sky_macros.svh"

module night_sky (
	input  logic                  frame_Clk,
	input  logic                  Reset,
	input  logic [`COORD_W-1:0]   write_x,
	input  logic [`COORD_W-1:0]   write_y,
	input  logic                  isnight,
	output sky_pkg::sky_layer_t   moon_on_wr,
	output logic [`SPRITE_AW-1:0] address
);
	import sky_pkg::*;

	moon_phase_t         phase;
	star_frame_t         star_frame;
	logic [`COORD_W-1:0] dist_x;
	logic [`COORD_W-1:0] dist_y;

	// per-frame animation state
	sky_animator u_animator (
		.frame_Clk  (frame_Clk),
		.Reset      (Reset),
		.isnight    (isnight),
		.phase      (phase),
		.star_frame (star_frame)
	);

	// layer goes straight out as moon_on_wr
	sky_hit_detect u_hit_detect (
		.write_x    (write_x),
		.write_y    (write_y),
		.isnight    (isnight),
		.phase      (phase),
		.star_frame (star_frame),
		.layer      (moon_on_wr),
		.dist_x     (dist_x),
		.dist_y     (dist_y)
	);

	draw_moon u_draw_moon (
		.layer      (moon_on_wr),
		.phase      (phase),
		.star_frame (star_frame),
		.dist_x     (dist_x),
		.dist_y     (dist_y),
		.address    (address)
	);

endmodule

// File: verilog/sky_animator.sv
`include "sky_macros.svh"

module sky_animator (
	input  logic                 frame_Clk,
	input  logic                 Reset,
	input  logic                 isnight,
	output sky_pkg::moon_phase_t phase,
	output sky_pkg::star_frame_t star_frame
);
	import sky_pkg::*;

	localparam int CNT_W = $clog2(`TWINKLE_PERIOD + 1);
	localparam moon_phase_t LAST_PHASE = 3'd6;

	// position inside the twinkle period, runs 1 up to the period
	logic [CNT_W-1:0] frame_count;
	logic [CNT_W-1:0] count_next;
	moon_phase_t      phase_next;

	assign count_next = frame_count + CNT_W'(1);

	// last right half wraps back to the full disc
	always_comb
	begin
		if (phase == LAST_PHASE)
			phase_next = 3'd0;
		else
			phase_next = phase + 3'd1;
	end

	always_ff @(posedge frame_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			frame_count <= CNT_W'(1);
			star_frame  <= 2'd0;
			phase       <= 3'd0;
		end
		else if (isnight)
		begin
			if (count_next == CNT_W'(`TWINKLE_PERIOD))
			begin
				// period done, restart twinkle and move the moon on
				frame_count <= CNT_W'(1);
				star_frame  <= 2'd0;
				phase       <= phase_next;
			end
			else
			begin
				frame_count <= count_next;
				if (count_next == CNT_W'(`TWINKLE_STEP1))
					star_frame <= 2'd1;
				else if (count_next == CNT_W'(`TWINKLE_STEP2))
					star_frame <= 2'd2;
			end
		end
	end

	// third star image is encoded 2, never 3
	star_frame_legal: assert property (@(posedge frame_Clk) disable iff (Reset)
		star_frame != 2'd3)
		else $error("star frame holds the unused code 3");

	phase_legal: assert property (@(posedge frame_Clk) disable iff (Reset)
		phase <= LAST_PHASE)
		else $error("moon phase went past the last right half");

	// daytime freezes the whole animation
	day_holds: assert property (@(posedge frame_Clk) disable iff (Reset)
		!isnight |=> $stable(phase) && $stable(star_frame))
		else $error("animation moved while isnight was low");

endmodule

// File: verilog/sky_hit_detect.sv
`include "sky_macros.svh"

module sky_hit_detect (
	input  logic [`COORD_W-1:0]  write_x,
	input  logic [`COORD_W-1:0]  write_y,
	input  logic                 isnight,
	input  sky_pkg::moon_phase_t phase,
	input  sky_pkg::star_frame_t star_frame,
	output sky_pkg::sky_layer_t  layer,
	output logic [`COORD_W-1:0]  dist_x,
	output logic [`COORD_W-1:0]  dist_y
);
	import sky_pkg::*;

	logic [`COORD_W-1:0] moon_x;
	logic [`COORD_W-1:0] moon_w;
	logic [`COORD_W-1:0] star_h;
	logic                in_moon;
	logic                in_star1;
	logic                in_star2;

	// moon footprint depends on which half is showing
	always_comb
	begin
		if (phase == 3'd0)
		begin
			moon_x = `COORD_W'(`MOON_X);
			moon_w = `COORD_W'(`MOON_FULL_W);
		end
		else if (phase <= 3'd3)
		begin
			moon_x = `COORD_W'(`MOON_X);
			moon_w = `COORD_W'(`MOON_HALF_W);
		end
		else
		begin
			moon_x = `COORD_W'(`MOON_RIGHT_X);
			moon_w = `COORD_W'(`MOON_HALF_W);
		end
	end

	// each twinkle image has its own height
	always_comb
	begin
		case (star_frame)
			2'd1:    star_h = `COORD_W'(`STAR_H1);
			2'd2:    star_h = `COORD_W'(`STAR_H2);
			default: star_h = `COORD_W'(`STAR_H0);
		endcase
	end

	// half-open boxes, right and bottom edge excluded
	assign in_moon = (write_x >= moon_x) && (write_x < moon_x + moon_w)
		&& (write_y >= `COORD_W'(`MOON_Y))
		&& (write_y < `COORD_W'(`MOON_Y + `MOON_H));

	assign in_star1 = (write_x >= `COORD_W'(`STAR1_X))
		&& (write_x < `COORD_W'(`STAR1_X + `STAR_W))
		&& (write_y >= `COORD_W'(`STAR1_Y))
		&& (write_y < `COORD_W'(`STAR1_Y) + star_h);

	assign in_star2 = (write_x >= `COORD_W'(`STAR2_X))
		&& (write_x < `COORD_W'(`STAR2_X + `STAR_W))
		&& (write_y >= `COORD_W'(`STAR2_Y))
		&& (write_y < `COORD_W'(`STAR2_Y) + star_h);

	// moon wins over star 1, star 1 over star 2
	always_comb
	begin
		layer  = LAYER_NONE;
		dist_x = '0;
		dist_y = '0;
		if (isnight)
		begin
			if (in_moon)
			begin
				layer  = LAYER_MOON;
				dist_x = write_x - moon_x;
				dist_y = write_y - `COORD_W'(`MOON_Y);
			end
			else if (in_star1)
			begin
				layer  = LAYER_STAR1;
				dist_x = write_x - `COORD_W'(`STAR1_X);
				dist_y = write_y - `COORD_W'(`STAR1_Y);
			end
			else if (in_star2)
			begin
				layer  = LAYER_STAR2;
				dist_x = write_x - `COORD_W'(`STAR2_X);
				dist_y = write_y - `COORD_W'(`STAR2_Y);
			end
		end
	end

	// nothing of the sky may show in daylight
	always_comb
	begin
		day_is_empty: assert #0 (isnight || layer == LAYER_NONE)
			else $error("sky layer active while isnight is low");
	end

endmodule

// File: verilog/sky_macros.svh
`ifndef SKY_MACROS_SVH
`define SKY_MACROS_SVH

// sprite memory address width
`define SPRITE_AW 18

// moon images: full disc, left halves 1..3, right halves 1..3
`define MOON_BASE0 142615
`define MOON_BASE1 149015
`define MOON_BASE2 152215
`define MOON_BASE3 155415
`define MOON_BASE4 158615
`define MOON_BASE5 161815
`define MOON_BASE6 165015

// three twinkle images, same width, slightly different heights
`define STAR_BASE0 224411
`define STAR_BASE1 224717
`define STAR_BASE2 225059

`define MOON_FULL_W 80
`define MOON_HALF_W 40
`define MOON_H      80

`define STAR_W  18
`define STAR_H0 17
`define STAR_H1 19
`define STAR_H2 18

// screen placement, top-left corners
`define MOON_X       0
`define MOON_RIGHT_X 40
`define MOON_Y       80
`define STAR1_X      100
`define STAR1_Y      20
`define STAR2_X      200
`define STAR2_Y      60

// animation timing in frames
`define TWINKLE_PERIOD 30
`define TWINKLE_STEP1  10
`define TWINKLE_STEP2  20

`define COORD_W 10

`endif

// File: verilog/sky_pkg.sv
package sky_pkg;

	// which sprite covers the pixel being written
	typedef enum logic [1:0]
	{
		LAYER_NONE  = 2'b00,
		LAYER_MOON  = 2'b01,
		LAYER_STAR1 = 2'b10,
		LAYER_STAR2 = 2'b11
	} sky_layer_t;

	// 0 full moon, 1..3 left halves, 4..6 right halves
	typedef logic [2:0] moon_phase_t;

	// star image 0..2
	typedef logic [1:0] star_frame_t;

endpackage
